// ==== rtl/fbTxtPkg.sv ====
// widths, screen constants and packed structs for the text-mode pixel pipeline
package fbTxtPkg;

	localparam int PosW    = 12;	// pixel position, per axis
	localparam int CellIxW = 14;	// display memory cell index
	localparam int GlyphW  = 16;
	localparam int FontW   = 64;	// one 8x8 font block
	localparam int CellW   = 32;

	// columns per row, 640 and 800 pixel widths
	localparam int Cols40  = 40;
	localparam int Cols80  = 80;
	localparam int Cols50  = 50;
	localparam int Cols100 = 100;

	localparam int RowLimit25 = 27;
	localparam int RowLimit50 = 52;
	localparam int SkipRows   = 2;	// top rows hidden above the index origin

	// border colour chroma, luma is zero
	localparam int BorderU = 128;
	localparam int BorderV = 128;

	typedef struct packed
	{
		logic [PosW-1:0] x;
		logic [PosW-1:0] y;
	} pixPosT;

	typedef struct packed
	{
		logic col80;
		logic row50;
		logic horz800;
	} dispCtrlT;

	typedef struct packed
	{
		logic [3:0] fx;	// 4x4 bitmap bit index
		logic [5:0] gx;	// 8x8 glyph bit index
		logic       outside;
		logic       border;
	} cellPosT;

	// cell tag, bits 31:30 of the cell word
	typedef enum logic [1:0]
	{
		textCell   = 2'b00,
		bitmapCell = 2'b01
	} cellKindT;

	typedef struct packed
	{
		logic [5:0] y6;
		logic [4:0] u5;
		logic [4:0] v5;
	} yuv16T;

	typedef struct packed
	{
		cellKindT          kind;
		logic              blinkForced;
		logic [GlyphW-1:0] bits;	// bitmap bits of a bitmap cell
		logic [3:0]        fx;
		logic [5:0]        gx;
		logic              border;
		yuv16T             endA;	// foreground
		yuv16T             endB;	// background
	} execOutT;

	typedef struct packed
	{
		logic [7:0] y;
		logic [7:0] u;
		logic [7:0] v;
	} pixYuvT;

endpackage

// ==== rtl/rgbToYuv.sv ====
// 12-bit RGB endpoint to packed 16-bit YUV
`timescale 1ns/10ps

module rgbToYuv
(
	input  logic [11:0]     rgb,
	output fbTxtPkg::yuv16T yuv
);

	logic [3:0] r;
	logic [3:0] g;
	logic [3:0] b;

	assign r = rgb[11:8];
	assign g = rgb[7:4];
	assign b = rgb[3:0];

	// luma weights green double, taking its field with one bit of blue
	assign yuv.y6 = {1'b0, rgb[7:3]} + {2'b0, r} + {2'b0, b};

	// chroma centred on 16
	assign yuv.u5 = 5'd16 + ({1'b0, b} - {1'b0, g});
	assign yuv.v5 = 5'd16 + ({1'b0, r} - {1'b0, g});

endmodule

// ==== rtl/cellAddrDecode.sv ====
// position register, cell index, sub-pixel indices, limit and border flags
`timescale 1ns/10ps

module cellAddrDecode
(
	input  logic                         clock,
	input  logic                         arstN,
	input  fbTxtPkg::pixPosT             pixPos,
	input  fbTxtPkg::dispCtrlT           dispCtrl,
	output logic [fbTxtPkg::CellIxW-1:0] pixCellIx,
	output fbTxtPkg::cellPosT            cellPos
);

	fbTxtPkg::pixPosT   posQ;
	fbTxtPkg::dispCtrlT ctrlQ;

	logic [fbTxtPkg::CellIxW-1:0] cols;
	logic [fbTxtPkg::CellIxW-1:0] cellRow;
	logic [fbTxtPkg::CellIxW-1:0] cellCol;
	logic [fbTxtPkg::CellIxW-1:0] cellIx;
	logic [5:0]                   rowLimit;
	logic [2:0]                   subY;	// glyph row within the cell
	logic [2:0]                   subX;
	fbTxtPkg::cellPosT            posNext;

	always_comb
	begin
		if (ctrlQ.col80)
			cols = ctrlQ.horz800 ? fbTxtPkg::CellIxW'(fbTxtPkg::Cols100) :
				fbTxtPkg::CellIxW'(fbTxtPkg::Cols80);
		else
			cols = ctrlQ.horz800 ? fbTxtPkg::CellIxW'(fbTxtPkg::Cols50) :
				fbTxtPkg::CellIxW'(fbTxtPkg::Cols40);

		// 8 or 16 pixel tall cells
		cellRow  = fbTxtPkg::CellIxW'(posQ.y >> (ctrlQ.row50 ? 3 : 4));
		cellCol  = fbTxtPkg::CellIxW'(posQ.x >> (ctrlQ.col80 ? 3 : 4));
		rowLimit = ctrlQ.row50 ? 6'(fbTxtPkg::RowLimit50) : 6'(fbTxtPkg::RowLimit25);

		// wraps for rows above SkipRows
		cellIx = cellRow * cols + cellCol - fbTxtPkg::CellIxW'(fbTxtPkg::SkipRows) * cols;

		// wide cells step the glyph every second pixel
		subY = ctrlQ.row50 ? posQ.y[2:0] : posQ.y[3:1];
		subX = ctrlQ.col80 ? posQ.x[2:0] : posQ.x[3:1];

		posNext.gx      = {3'd7 - subY, 3'd7 - subX};
		posNext.fx      = {2'd3 - subY[2:1], 2'd3 - subX[2:1]};
		posNext.outside = (cellCol >= cols) || (cellRow[5:0] >= rowLimit);
		posNext.border  = posQ.x[11] | posQ.y[11];
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			posQ      <= '0;
			ctrlQ     <= '0;
			pixCellIx <= '0;
			cellPos   <= '0;
		end
		else
		begin
			posQ      <= pixPos;	// edge 0
			ctrlQ     <= dispCtrl;
			pixCellIx <= cellIx;	// edge 1, request to display memory
			cellPos   <= posNext;
		end
	end

endmodule

// ==== rtl/cellColorExec.sv ====
// cell word decode into glyph, blink flag and two YUV colour endpoints
`timescale 1ns/10ps

module cellColorExec
(
	input  logic                         clock,
	input  logic                         arstN,
	input  fbTxtPkg::cellPosT            cellPos,
	input  logic [fbTxtPkg::CellW-1:0]   cellWord,
	input  logic                         blinkSlow,
	input  logic                         blinkFast,
	output logic [fbTxtPkg::GlyphW-1:0]  fontGlyph,
	output fbTxtPkg::execOutT            execOut
);

	logic [fbTxtPkg::CellW-1:0]  word;
	logic [fbTxtPkg::GlyphW-1:0] glyph;
	fbTxtPkg::cellKindT          kind;
	logic                        blinkForced;
	logic [11:0]                 rgbA;
	logic [11:0]                 rgbB;
	fbTxtPkg::yuv16T             yuvA;
	fbTxtPkg::yuv16T             yuvB;
	fbTxtPkg::execOutT           execNext;

	// 6-bit endpoints repeat each 2-bit channel, 9-bit ones pad a zero below
	function automatic logic [11:0] expandRgb(input logic [1:0] tag, input logic [5:0] c6,
		input logic [8:0] c9);
		logic [11:0] rgb;
		case (tag)
			2'b00:   rgb = {c6[5:4], c6[5:4], c6[3:2], c6[3:2], c6[1:0], c6[1:0]};
			2'b10:   rgb = {c9[8:6], 1'b0, c9[5:3], 1'b0, c9[2:0], 1'b0};
			default: rgb = '0;	// unused colour tags show black
		endcase
		return rgb;
	endfunction

	always_comb
	begin
		word  = cellPos.outside ? '0 : cellWord;	// blank cell off screen
		glyph = word[15:0];
		kind  = fbTxtPkg::cellKindT'(word[31:30]);

		rgbA = expandRgb(word[29:28], word[21:16], word[18:10]);
		rgbB = expandRgb(word[29:28], word[27:22], word[27:19]);

		blinkForced = 1'b0;
		if (kind == fbTxtPkg::textCell)
		begin
			case (glyph[15:14])
				2'b01:   blinkForced = blinkFast;
				2'b10:   blinkForced = blinkSlow;
				default: blinkForced = 1'b0;	// 11 is steady
			endcase
		end
	end

	rgbToYuv rgbToYuvA_i
	(
		.rgb (rgbA),
		.yuv (yuvA)
	);

	rgbToYuv rgbToYuvB_i
	(
		.rgb (rgbB),
		.yuv (yuvB)
	);

	always_comb
	begin
		execNext.kind        = kind;
		execNext.blinkForced = blinkForced;
		execNext.bits        = glyph;
		execNext.fx          = cellPos.fx;
		execNext.gx          = cellPos.gx;
		execNext.border      = cellPos.border;
		execNext.endA        = yuvA;
		execNext.endB        = yuvB;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			fontGlyph <= '0;
			execOut   <= '0;
		end
		else
		begin
			fontGlyph <= glyph;	// edge 2, font ROM address
			execOut   <= execNext;
		end
	end

endmodule

// ==== rtl/pixelResult.sv ====
// endpoint select by pixel bit and expansion into the 8-bit YUV pixel
`timescale 1ns/10ps

module pixelResult
(
	input  logic                       clock,
	input  logic                       arstN,
	input  fbTxtPkg::execOutT          execOut,
	input  logic [fbTxtPkg::FontW-1:0] fontData,
	output fbTxtPkg::pixYuvT           pixel
);

	logic              pixBit;
	fbTxtPkg::yuv16T   sel;
	fbTxtPkg::pixYuvT  pixNext;

	always_comb
	begin
		case (execOut.kind)
			fbTxtPkg::textCell:
				pixBit = execOut.blinkForced ? 1'b0 : fontData[execOut.gx];
			fbTxtPkg::bitmapCell:
				pixBit = execOut.bits[execOut.fx];
			default:
				pixBit = 1'b0;	// dropped cell types show background
		endcase

		sel = pixBit ? execOut.endA : execOut.endB;

		// repeat the top bits to fill 8 bits
		pixNext.y = {sel.y6, sel.y6[5:4]};
		pixNext.u = {sel.u5, sel.u5[4:2]};
		pixNext.v = {sel.v5, sel.v5[4:2]};

		if (execOut.border)
		begin
			pixNext.y = 8'd0;
			pixNext.u = 8'(fbTxtPkg::BorderU);
			pixNext.v = 8'(fbTxtPkg::BorderV);
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			pixel <= '0;
		else
			pixel <= pixNext;	// edge 3
	end

endmodule

// ==== rtl/fbTxtTop.sv ====
// top level of the text-mode pixel pipeline, decode then execute then result
`timescale 1ns/10ps

module fbTxtTop
(
	input  logic                             clock,
	input  logic                             arstN,
	input  fbTxtPkg::pixPosT                 pixPos,
	input  fbTxtPkg::dispCtrlT               dispCtrl,
	input  logic [fbTxtPkg::CellW-1:0]       cellWord,
	input  logic [fbTxtPkg::FontW-1:0]       fontData,
	input  logic                             blinkSlow,
	input  logic                             blinkFast,
	output logic [fbTxtPkg::CellIxW-1:0]     pixCellIx,
	output logic [fbTxtPkg::GlyphW-1:0]      fontGlyph,
	output fbTxtPkg::pixYuvT                 pixel
);

	fbTxtPkg::cellPosT cellPos;	// stage 1 to stage 2
	fbTxtPkg::execOutT execOut;	// stage 2 to stage 3

	cellAddrDecode cellAddrDecode_i
	(
		.clock     (clock),
		.arstN     (arstN),
		.pixPos    (pixPos),
		.dispCtrl  (dispCtrl),
		.pixCellIx (pixCellIx),
		.cellPos   (cellPos)
	);

	cellColorExec cellColorExec_i
	(
		.clock     (clock),
		.arstN     (arstN),
		.cellPos   (cellPos),
		.cellWord  (cellWord),
		.blinkSlow (blinkSlow),
		.blinkFast (blinkFast),
		.fontGlyph (fontGlyph),
		.execOut   (execOut)
	);

	pixelResult pixelResult_i
	(
		.clock    (clock),
		.arstN    (arstN),
		.execOut  (execOut),
		.fontData (fontData),
		.pixel    (pixel)
	);

endmodule

// ==== test/fbTxtTb.sv ====
// clock, reset, case reader, driver and checker of the text-mode pixel pipeline testbench
`timescale 1ns/10ps

module fbTxtTb;

	localparam int ResetCycles  = 5;
	localparam int SettleCycles = 6;	// three stage latency with margin
	localparam int WaitLimit    = 100;
	localparam int MaxLines     = 1000;

	logic                         clock = 1'b0;
	logic                         arstN;
	fbTxtPkg::pixPosT             pixPos;
	fbTxtPkg::dispCtrlT           dispCtrl;
	logic [fbTxtPkg::CellW-1:0]   cellWord;
	logic [fbTxtPkg::FontW-1:0]   fontData;
	logic                         blinkSlow;
	logic                         blinkFast;
	logic [fbTxtPkg::CellIxW-1:0] pixCellIx;
	logic [fbTxtPkg::GlyphW-1:0]  fontGlyph;
	fbTxtPkg::pixYuvT             pixel;

	// fields of the current case line
	string                        caseName;
	logic [2:0]                   ctrlIn;	// col80, row50, horz800
	logic [fbTxtPkg::PosW-1:0]    xIn;
	logic [fbTxtPkg::PosW-1:0]    yIn;
	logic [fbTxtPkg::CellW-1:0]   wordIn;
	logic [fbTxtPkg::FontW-1:0]   fontIn;
	logic                         slowIn;
	logic                         fastIn;
	logic [fbTxtPkg::CellIxW-1:0] expIx;
	logic [fbTxtPkg::GlyphW-1:0]  expGlyph;
	logic [7:0]                   expY;
	logic [7:0]                   expU;
	logic [7:0]                   expV;
	int                           caseCount;

	fbTxtTop fbTxtTop_i
	(
		.clock     (clock),
		.arstN     (arstN),
		.pixPos    (pixPos),
		.dispCtrl  (dispCtrl),
		.cellWord  (cellWord),
		.fontData  (fontData),
		.blinkSlow (blinkSlow),
		.blinkFast (blinkFast),
		.pixCellIx (pixCellIx),
		.fontGlyph (fontGlyph),
		.pixel     (pixel)
	);

	always #5 clock = ~clock;	// 10 ns period

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
			abortRun($sformatf("ERROR %s %s expected %h actual %h", caseName, field,
				expected, actual));
	endtask

	// counts falling edges where outputs are stable
	task automatic waitCycles(input int cycles);
		int count;
		count = 0;
		while (count < cycles)
		begin
			@(negedge clock);
			count++;
			if (count >= WaitLimit)
				abortRun("timeout while waiting for a falling clock edge");
		end
	endtask

	// rising edges where the inputs change
	task automatic waitRising(input int cycles);
		int count;
		count = 0;
		while (count < cycles)
		begin
			@(posedge clock);
			count++;
			if (count >= WaitLimit)
				abortRun("timeout while waiting for a rising clock edge");
		end
	endtask

	task automatic resetDut();
		waitRising(ResetCycles);
		arstN <= 1'b1;
	endtask

	// inputs held for the whole case keep memory answers in time
	task automatic runCase();
		waitRising(1);
		pixPos.x  <= xIn;
		pixPos.y  <= yIn;
		dispCtrl  <= fbTxtPkg::dispCtrlT'(ctrlIn);
		cellWord  <= wordIn;
		fontData  <= fontIn;
		blinkSlow <= slowIn;
		blinkFast <= fastIn;
		waitCycles(SettleCycles);
		checkValue("pixCellIx", 64'(expIx), 64'(pixCellIx));
		checkValue("fontGlyph", 64'(expGlyph), 64'(fontGlyph));
		checkValue("pixel.y", 64'(expY), 64'(pixel.y));
		checkValue("pixel.u", 64'(expU), 64'(pixel.u));
		checkValue("pixel.v", 64'(expV), 64'(pixel.v));
	endtask

	initial
	begin
		int    fd;
		int    lineCount;
		int    fields;
		string line;

		arstN     = 1'b0;
		pixPos    = '0;
		dispCtrl  = '0;
		cellWord  = '0;
		fontData  = '0;
		blinkSlow = 1'b0;
		blinkFast = 1'b0;
		caseName  = "reset";
		caseCount = 0;
		lineCount = 0;

		resetDut();
		waitCycles(1);	// no edge sampled since reset release
		checkValue("pixCellIx", 64'd0, 64'(pixCellIx));
		checkValue("fontGlyph", 64'd0, 64'(fontGlyph));
		checkValue("pixel", 64'd0, 64'(pixel));

		fd = $fopen("test/fbTxtCases.txt", "r");
		if (fd == 0)
			abortRun("could not open the case file test/fbTxtCases.txt");

		while (!$feof(fd) && lineCount < MaxLines)
		begin
			line = "";
			void'($fgets(line, fd));
			lineCount++;
			if (line.len() > 1 && line[0] != "#")	// skip comments and blank lines
			begin
				fields = $sscanf(line, "%s %h %h %h %h %h %b %b %h %h %h %h %h",
					caseName, ctrlIn, xIn, yIn, wordIn, fontIn, slowIn, fastIn,
					expIx, expGlyph, expY, expU, expV);
				if (fields != 13)
					abortRun($sformatf("case file line %0d has %0d fields instead of 13",
						lineCount, fields));
				runCase();
				caseCount++;
			end
		end
		if (!$feof(fd))
			abortRun("case file has more lines than the reader allows");
		$fclose(fd);

		if (caseCount == 0)
			abortRun("the case file holds no cases");
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== test/fbTxtCases.txt ====
# name ctrl(col80 row50 horz800) x y cellWord fontData blinkSlow blinkFast
#   expected: pixCellIx fontGlyph y u v, all numbers hex except the blink bits
idx40 0 050 040 00000041 0000000000000000 0 0 0055 0041 00 84 84
idx80 4 100 0a0 00000041 0000000000000000 0 0 02a0 0041 00 84 84
idx50 1 300 180 00000041 0000000000000000 0 0 047c 0041 00 84 84
idx100row50 7 318 198 00000041 0000000000000000 0 0 1387 0041 00 84 84
wrap40 0 020 008 00000041 0000000000000000 0 0 3fb2 0041 00 84 84
wrapRow50 2 010 008 00000041 0000000000000000 0 0 3fd9 0041 00 84 84
outsideCol 0 280 040 0fff0041 0000000000000000 0 0 0078 0000 00 84 84
outsideRow 0 040 1b0 0fff0041 0000000000000000 0 0 03ec 0000 00 84 84
borderX 0 840 040 0fff0041 0000000000000000 0 0 00d4 0000 00 80 80
borderY 0 040 840 0fff0041 0000000000000000 0 0 1454 0041 00 80 80
textFg 0 050 040 03300041 8000000000000000 0 0 0055 0041 3c 84 ff
textBg 0 05e 04e 03300041 8000000000000000 0 0 0055 0041 79 08 08
textMid 0 052 044 03300041 0000400000000000 0 0 0055 0041 3c 84 ff
text80Row50 6 103 0a5 03300041 0000000000100000 0 0 05c0 0041 3c 84 ff
bitmapFx15 0 050 040 603ffc00 0000000000000000 0 0 0055 fc00 e7 84 84
bitmapFx0 0 05c 04c 603ffc00 0000000000000000 0 0 0055 fc00 3c f7 84
bitmapFx10 0 054 044 603ffc00 0000000000000000 0 0 0055 fc00 e7 84 84
bitmapFx9 0 058 044 603ffc00 0000000000000000 0 0 0055 fc00 3c f7 84
blinkFastOn 0 050 040 03304041 8000000000000000 0 1 0055 4041 79 08 08
blinkFastIdle 0 050 040 03304041 8000000000000000 1 0 0055 4041 3c 84 ff
blinkSlowOn 0 050 040 03308041 8000000000000000 1 0 0055 8041 79 08 08
blinkSteady 0 050 040 0330c041 8000000000000000 1 1 0055 c041 3c 84 ff
colourTagBlack 0 050 040 13300041 8000000000000000 0 0 0055 0041 00 84 84

// ==== files.f ====
rtl/fbTxtPkg.sv
rtl/rgbToYuv.sv
rtl/cellAddrDecode.sv
rtl/cellColorExec.sv
rtl/pixelResult.sv
rtl/fbTxtTop.sv
test/fbTxtTb.sv

// ==== Makefile ====
# Verilator build and run of the text-mode pixel pipeline testbench

TOP   = fbTxtTb
BUILD = build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run into sim.log, check for the pass message"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wall -Wno-fatal --top-module $(TOP) \
		--Mdir $(BUILD) -f files.f
	./$(BUILD)/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log
